// File: hw/qpll_ctrl_params.svh
`ifndef QPLL_CTRL_PARAMS_SVH
`define QPLL_CTRL_PARAMS_SVH

//////////////////////////////////////////////////
// Register map, byte offsets on the APB bus

`define QPLL_ADDR_CTRL			8'h00	//Refclk select and power-down
`define QPLL_ADDR_RESET			8'h04	//Write-1 reset strobes
`define QPLL_ADDR_SDM_DATA0		8'h08	//Fractional word, PLL0
`define QPLL_ADDR_SDM_DATA1		8'h0C	//Fractional word, PLL1
`define QPLL_ADDR_SDM_LOAD		8'h10	//Write-1 load strobes, reads busy
`define QPLL_ADDR_STATUS		8'h14	//Read-only lock/lost/fail flags

//Refclk mux select after reset, GTREFCLK0
`define REFCLK_SEL_DEFAULT		1

//////////////////////////////////////////////////
// Reset sequencer timing, in pclk cycles

`define QPLL_RST_CYCLES			16		//Width of each reset pulse
`define QPLL_LOCK_TIMEOUT		256		//Lock wait before a retry
`define QPLL_MAX_RETRY			3		//Pulses before giving up

//////////////////////////////////////////////////
// SDM load timing required by the hard block

//Toggle high with data stable
`define SDM_PULSE_CYCLES		3
//Toggle low, data must not change yet
`define SDM_HOLD_CYCLES			3

`endif

// File: hw/qpll_regmap_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// Bus-side view of the PLL control block

package qpll_regmap_pkg;

	//Byte address, only the low 8 bits of the bus are decoded
	typedef logic[7:0]		apb_addr_t;

	//Full width APB data
	typedef logic[31:0]		apb_data_t;

	/*
		Decoded register, one per 32-bit word of the map.
		REG_NONE covers unmapped and unaligned addresses,
		which the completer answers with pslverr
	 */
	typedef enum logic[2:0]
	{
		REG_CTRL		= 3'd0,		//Refclk select, power-down
		REG_RESET		= 3'd1,		//Reset request strobes
		REG_SDM_DATA0	= 3'd2,		//Fractional word of PLL0
		REG_SDM_DATA1	= 3'd3,		//Fractional word of PLL1
		REG_SDM_LOAD	= 3'd4,		//Load strobes and busy flags
		REG_STATUS		= 3'd5,		//Lock, lost and fail flags
		REG_NONE		= 3'd7		//Decode miss
	} reg_index_t;

endpackage

`default_nettype wire

// File: hw/qpll_ctrl_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// PLL-side control types

package qpll_ctrl_pkg;

	typedef logic[2:0]		refclk_sel_t;	//QPLLxREFCLKSEL encoding
	typedef logic[24:0]		sdm_word_t;		//SDMxDATA, 24 bit denominator mode
	typedef logic[1:0]		retry_cnt_t;	//Consecutive lock timeouts

	//Reset / lock sequencer
	typedef enum logic[2:0]
	{
		RST_PD,			//Powered down, reset held
		RST_PULSE,		//Driving qpll_reset
		RST_WAIT,		//Reset released, waiting for lock
		RST_LOCKED,		//Up and running
		RST_FAIL		//Out of retries
	} rst_state_t;

	//SDM toggle sequencer
	typedef enum logic[1:0]
	{
		SDM_IDLE,
		SDM_SETUP,		//New data on the pins, toggle still low
		SDM_PULSE,		//Toggle high
		SDM_HOLD		//Toggle low, data frozen
	} sdm_state_t;

endpackage

`default_nettype wire

// File: hw/qpll_cfg_if.sv
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////
// Control link between the register block and the
// per-PLL reset sequencer and SDM loader

interface qpll_cfg_if;

	//Static configuration
	qpll_ctrl_pkg::refclk_sel_t	refclk_sel;		//To the PLL pin via top level
	logic						powerdown;		//Forces the sequencer into RST_PD

	//Reset request, single cycle strobe
	logic						rst_req;

	//Fractional-N load request
	qpll_ctrl_pkg::sdm_word_t	sdm_word;		//Current SDM_DATA register
	logic						sdm_start;		//Single cycle strobe

	//Status back to the register block
	logic						locked;
	logic						failed;
	logic						sdm_busy;

	modport regs(
		output	refclk_sel, powerdown, rst_req, sdm_word, sdm_start,
		input	locked, failed, sdm_busy
	);

	modport rst_ctl(
		input	powerdown, rst_req,
		output	locked, failed
	);

	modport sdm(
		input	sdm_word, sdm_start,
		output	sdm_busy
	);

endinterface

`default_nettype wire

// File: hw/qpll_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "qpll_ctrl_params.svh"

module qpll_apb_regs(
	input wire								pclk,
	input wire								rst_n,

	//APB completer with zero wait states
	input wire								psel,
	input wire								penable,
	input wire								pwrite,
	input wire qpll_regmap_pkg::apb_addr_t	paddr,
	input wire qpll_regmap_pkg::apb_data_t	pwdata,
	output qpll_regmap_pkg::apb_data_t		prdata,
	output logic							pready,
	output logic							pslverr,

	//Async status from the hard block
	input wire[1:0]							refclk_lost,
	input wire[1:0]							fbclk_lost,

	//One link per PLL
	qpll_cfg_if.regs						cfg0,
	qpll_cfg_if.regs						cfg1
);

	//////////////////////////////////////////////////
	// Address decode

	qpll_regmap_pkg::reg_index_t	idx;
	logic							access;
	logic							wr_en;

	//Unaligned offsets never match an entry, so they fall out as REG_NONE
	always_comb begin
		case(paddr)
			`QPLL_ADDR_CTRL:		idx = qpll_regmap_pkg::REG_CTRL;
			`QPLL_ADDR_RESET:		idx = qpll_regmap_pkg::REG_RESET;
			`QPLL_ADDR_SDM_DATA0:	idx = qpll_regmap_pkg::REG_SDM_DATA0;
			`QPLL_ADDR_SDM_DATA1:	idx = qpll_regmap_pkg::REG_SDM_DATA1;
			`QPLL_ADDR_SDM_LOAD:	idx = qpll_regmap_pkg::REG_SDM_LOAD;
			`QPLL_ADDR_STATUS:		idx = qpll_regmap_pkg::REG_STATUS;
			default:				idx = qpll_regmap_pkg::REG_NONE;
		endcase
	end

	assign access	= psel && penable;		//Second phase of the transfer
	assign wr_en	= access && pwrite;
	assign pready	= access;				//Never stall
	assign pslverr	= access && (idx == qpll_regmap_pkg::REG_NONE);

	//////////////////////////////////////////////////
	// Configuration registers

	qpll_ctrl_pkg::refclk_sel_t		sel0;
	qpll_ctrl_pkg::refclk_sel_t		sel1;
	logic[1:0]						pd;
	qpll_ctrl_pkg::sdm_word_t		sdm0;
	qpll_ctrl_pkg::sdm_word_t		sdm1;
	logic[1:0]						rst_req_q;
	logic[1:0]						sdm_start_q;

	always_ff @(posedge pclk or negedge rst_n) begin
		if(!rst_n) begin
			sel0		<= qpll_ctrl_pkg::refclk_sel_t'(`REFCLK_SEL_DEFAULT);
			sel1		<= qpll_ctrl_pkg::refclk_sel_t'(`REFCLK_SEL_DEFAULT);
			pd			<= 2'b00;
			sdm0		<= '0;
			sdm1		<= '0;
			rst_req_q	<= 2'b00;
			sdm_start_q	<= 2'b00;
		end
		else begin

			//Strobes only live for one cycle
			rst_req_q	<= 2'b00;
			sdm_start_q	<= 2'b00;

			if(wr_en) begin
				case(idx)
					qpll_regmap_pkg::REG_CTRL: begin
						sel0	<= pwdata[2:0];
						sel1	<= pwdata[6:4];
						pd		<= pwdata[9:8];
					end
					qpll_regmap_pkg::REG_RESET:		rst_req_q	<= pwdata[1:0];
					qpll_regmap_pkg::REG_SDM_DATA0:	sdm0		<= pwdata[24:0];
					qpll_regmap_pkg::REG_SDM_DATA1:	sdm1		<= pwdata[24:0];
					qpll_regmap_pkg::REG_SDM_LOAD:	sdm_start_q	<= pwdata[1:0];
					default: begin
						//STATUS is read-only and misses are dropped
					end
				endcase
			end
		end
	end

	//Out to the per-PLL blocks
	assign cfg0.refclk_sel	= sel0;
	assign cfg1.refclk_sel	= sel1;
	assign cfg0.powerdown	= pd[0];
	assign cfg1.powerdown	= pd[1];
	assign cfg0.rst_req		= rst_req_q[0];
	assign cfg1.rst_req		= rst_req_q[1];
	assign cfg0.sdm_word	= sdm0;
	assign cfg1.sdm_word	= sdm1;
	assign cfg0.sdm_start	= sdm_start_q[0];
	assign cfg1.sdm_start	= sdm_start_q[1];

	//////////////////////////////////////////////////
	// Lost flag synchronizer and read path

	logic[3:0]						lost_meta;	//{fbclk, refclk}
	logic[3:0]						lost_sync;
	qpll_regmap_pkg::apb_data_t		rdata;

	always_ff @(posedge pclk or negedge rst_n) begin
		if(!rst_n) begin
			lost_meta	<= 4'h0;
			lost_sync	<= 4'h0;
		end
		else begin
			lost_meta	<= {fbclk_lost, refclk_lost};
			lost_sync	<= lost_meta;
		end
	end

	always_comb begin
		case(idx)
			qpll_regmap_pkg::REG_CTRL:		rdata = {22'h0, pd, 1'b0, sel1, 1'b0, sel0};
			qpll_regmap_pkg::REG_SDM_DATA0:	rdata = {7'h0, sdm0};
			qpll_regmap_pkg::REG_SDM_DATA1:	rdata = {7'h0, sdm1};
			qpll_regmap_pkg::REG_SDM_LOAD:	rdata = {30'h0, cfg1.sdm_busy, cfg0.sdm_busy};
			qpll_regmap_pkg::REG_STATUS: begin
				rdata = {24'h0, cfg1.failed, cfg0.failed, lost_sync,
					cfg1.locked, cfg0.locked};
			end
			default:						rdata = '0;	//RESET is write-only
		endcase
	end

	assign prdata = (access && !pwrite) ? rdata : '0;

endmodule

`default_nettype wire

// File: hw/qpll_reset_ctl.sv
`timescale 1ns/100ps
`default_nettype none

`include "qpll_ctrl_params.svh"

module qpll_reset_ctl(
	input wire				pclk,
	input wire				rst_n,

	input wire				pll_lock,		//Async from the hard block
	output logic			qpll_reset,

	qpll_cfg_if.rst_ctl		cfg
);

	//One counter covers both the pulse and the lock wait
	localparam int CNT_W = $clog2((`QPLL_LOCK_TIMEOUT > `QPLL_RST_CYCLES) ?
		`QPLL_LOCK_TIMEOUT : `QPLL_RST_CYCLES);

	localparam logic[CNT_W-1:0] PULSE_LOAD	= CNT_W'(`QPLL_RST_CYCLES - 1);
	localparam logic[CNT_W-1:0] WAIT_LOAD	= CNT_W'(`QPLL_LOCK_TIMEOUT - 1);

	//////////////////////////////////////////////////
	// Lock synchronizer

	logic	lock_meta;
	logic	lock_sync;

	always_ff @(posedge pclk or negedge rst_n) begin
		if(!rst_n) begin
			lock_meta	<= 1'b0;
			lock_sync	<= 1'b0;
		end
		else begin
			lock_meta	<= pll_lock;
			lock_sync	<= lock_meta;
		end
	end

	//////////////////////////////////////////////////
	// Sequencer

	qpll_ctrl_pkg::rst_state_t	state;
	qpll_ctrl_pkg::rst_state_t	state_nxt;
	logic[CNT_W-1:0]			cnt;
	logic[CNT_W-1:0]			cnt_nxt;
	qpll_ctrl_pkg::retry_cnt_t	retry_cnt;
	qpll_ctrl_pkg::retry_cnt_t	retry_nxt;

	always_comb begin
		state_nxt	= state;
		cnt_nxt		= cnt;
		retry_nxt	= retry_cnt;

		//Power-down wins over everything
		if(cfg.powerdown) begin
			state_nxt	= qpll_ctrl_pkg::RST_PD;
			retry_nxt	= '0;
		end

		//Software restart, fresh retry budget
		else if(cfg.rst_req && (state != qpll_ctrl_pkg::RST_PD)) begin
			state_nxt	= qpll_ctrl_pkg::RST_PULSE;
			cnt_nxt		= PULSE_LOAD;
			retry_nxt	= '0;
		end

		else begin
			case(state)
				qpll_ctrl_pkg::RST_PD: begin		//Power-down just released
					state_nxt	= qpll_ctrl_pkg::RST_PULSE;
					cnt_nxt		= PULSE_LOAD;
				end
				qpll_ctrl_pkg::RST_PULSE: begin
					if(cnt == '0) begin
						state_nxt	= qpll_ctrl_pkg::RST_WAIT;
						cnt_nxt		= WAIT_LOAD;
					end
					else
						cnt_nxt		= cnt - 1'b1;
				end
				qpll_ctrl_pkg::RST_WAIT: begin
					if(lock_sync) begin
						state_nxt	= qpll_ctrl_pkg::RST_LOCKED;
						retry_nxt	= '0;
					end
					else if(cnt != '0)
						cnt_nxt		= cnt - 1'b1;
					//Timed out, last allowed attempt?
					else if(retry_cnt == qpll_ctrl_pkg::retry_cnt_t'(`QPLL_MAX_RETRY - 1))
						state_nxt	= qpll_ctrl_pkg::RST_FAIL;
					else begin
						state_nxt	= qpll_ctrl_pkg::RST_PULSE;
						cnt_nxt		= PULSE_LOAD;
						retry_nxt	= retry_cnt + 1'b1;
					end
				end
				qpll_ctrl_pkg::RST_LOCKED: begin
					if(!lock_sync) begin			//Lost lock, start over
						state_nxt	= qpll_ctrl_pkg::RST_PULSE;
						cnt_nxt		= PULSE_LOAD;
						retry_nxt	= '0;
					end
				end
				qpll_ctrl_pkg::RST_FAIL: begin
					//Parked until a reset request
				end
				default: begin
					state_nxt	= qpll_ctrl_pkg::RST_PULSE;
					cnt_nxt		= PULSE_LOAD;
				end
			endcase
		end
	end

	//Comes out of reset mid-pulse
	always_ff @(posedge pclk or negedge rst_n) begin
		if(!rst_n) begin
			state		<= qpll_ctrl_pkg::RST_PULSE;
			cnt			<= PULSE_LOAD;
			retry_cnt	<= '0;
			qpll_reset	<= 1'b1;
		end
		else begin
			state		<= state_nxt;
			cnt			<= cnt_nxt;
			retry_cnt	<= retry_nxt;
			qpll_reset	<= (state_nxt == qpll_ctrl_pkg::RST_PULSE) ||
				(state_nxt == qpll_ctrl_pkg::RST_PD);	//Registered, no glitches on the pin
		end
	end

	assign cfg.locked	= (state == qpll_ctrl_pkg::RST_LOCKED);
	assign cfg.failed	= (state == qpll_ctrl_pkg::RST_FAIL);

endmodule

`default_nettype wire

// File: hw/qpll_sdm_loader.sv
`timescale 1ns/100ps
`default_nettype none

`include "qpll_ctrl_params.svh"

module qpll_sdm_loader(
	input wire									pclk,
	input wire									rst_n,

	//To the hard block
	output qpll_ctrl_pkg::sdm_word_t			sdm_data,
	output logic								sdm_toggle,

	qpll_cfg_if.sdm								cfg
);

	//Wide enough for either phase
	localparam int PHASE_W = $clog2(`SDM_PULSE_CYCLES + `SDM_HOLD_CYCLES);

	qpll_ctrl_pkg::sdm_state_t	state;
	logic[PHASE_W-1:0]			phase_cnt;
	logic						start_ok;

	//Requests landing mid-sequence are dropped
	assign start_ok		= cfg.sdm_start && (state == qpll_ctrl_pkg::SDM_IDLE);
	assign cfg.sdm_busy	= (state != qpll_ctrl_pkg::SDM_IDLE);

	//////////////////////////////////////////////////
	// Data latch loaded as the setup cycle starts

	always_ff @(posedge pclk or negedge rst_n) begin
		if(!rst_n)
			sdm_data	<= '0;
		else if(start_ok)
			sdm_data	<= cfg.sdm_word;
	end

	//////////////////////////////////////////////////
	// Toggle sequencer

	always_ff @(posedge pclk or negedge rst_n) begin
		if(!rst_n) begin
			state		<= qpll_ctrl_pkg::SDM_IDLE;
			phase_cnt	<= '0;
			sdm_toggle	<= 1'b0;
		end
		else begin
			case(state)
				qpll_ctrl_pkg::SDM_IDLE: begin
					if(start_ok)
						state	<= qpll_ctrl_pkg::SDM_SETUP;
				end

				//One cycle of data ahead of the toggle
				qpll_ctrl_pkg::SDM_SETUP: begin
					state		<= qpll_ctrl_pkg::SDM_PULSE;
					sdm_toggle	<= 1'b1;
					phase_cnt	<= PHASE_W'(`SDM_PULSE_CYCLES - 1);
				end

				qpll_ctrl_pkg::SDM_PULSE: begin
					if(phase_cnt == '0) begin
						state		<= qpll_ctrl_pkg::SDM_HOLD;
						sdm_toggle	<= 1'b0;
						phase_cnt	<= PHASE_W'(`SDM_HOLD_CYCLES - 1);
					end
					else
						phase_cnt	<= phase_cnt - 1'b1;
				end

				qpll_ctrl_pkg::SDM_HOLD: begin
					if(phase_cnt == '0)
						state		<= qpll_ctrl_pkg::SDM_IDLE;	//Data free to change
					else
						phase_cnt	<= phase_cnt - 1'b1;
				end

				default: begin
					state		<= qpll_ctrl_pkg::SDM_IDLE;
					sdm_toggle	<= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/qpll_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module qpll_ctrl_top(
	input wire									pclk,
	input wire									rst_n,

	//APB completer
	input wire									psel,
	input wire									penable,
	input wire									pwrite,
	input wire qpll_regmap_pkg::apb_addr_t		paddr,
	input wire qpll_regmap_pkg::apb_data_t		pwdata,
	output wire qpll_regmap_pkg::apb_data_t		prdata,
	output wire									pready,
	output wire									pslverr,

	//Status from the hard block
	input wire[1:0]								qpll_lock,
	input wire[1:0]								refclk_lost,
	input wire[1:0]								fbclk_lost,

	//Control to the hard block
	output wire[1:0]							qpll_reset,
	output wire[1:0]							qpll_powerdown,
	output wire qpll_ctrl_pkg::refclk_sel_t		qpll0_refclk_sel,
	output wire qpll_ctrl_pkg::refclk_sel_t		qpll1_refclk_sel,
	output wire qpll_ctrl_pkg::sdm_word_t		sdm_data0,
	output wire qpll_ctrl_pkg::sdm_word_t		sdm_data1,
	output wire[1:0]							sdm_toggle
);

	//////////////////////////////////////////////////
	// Register block

	qpll_cfg_if cfg0();
	qpll_cfg_if cfg1();

	qpll_apb_regs u_regs(
		.pclk(pclk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.refclk_lost(refclk_lost),
		.fbclk_lost(fbclk_lost),
		.cfg0(cfg0),
		.cfg1(cfg1));

	//Static settings straight out to the pins
	assign qpll0_refclk_sel	= cfg0.refclk_sel;
	assign qpll1_refclk_sel	= cfg1.refclk_sel;
	assign qpll_powerdown	= {cfg1.powerdown, cfg0.powerdown};

	//////////////////////////////////////////////////
	// Per-PLL sequencers

	qpll_reset_ctl u_rst0(
		.pclk(pclk), .rst_n(rst_n), .pll_lock(qpll_lock[0]),
		.qpll_reset(qpll_reset[0]), .cfg(cfg0));

	qpll_reset_ctl u_rst1(
		.pclk(pclk), .rst_n(rst_n), .pll_lock(qpll_lock[1]),
		.qpll_reset(qpll_reset[1]), .cfg(cfg1));

	qpll_sdm_loader u_sdm0(
		.pclk(pclk), .rst_n(rst_n), .sdm_data(sdm_data0),
		.sdm_toggle(sdm_toggle[0]), .cfg(cfg0));

	qpll_sdm_loader u_sdm1(
		.pclk(pclk), .rst_n(rst_n), .sdm_data(sdm_data1),
		.sdm_toggle(sdm_toggle[1]), .cfg(cfg1));

endmodule

`default_nettype wire

// File: testbench/tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

//Free running pclk, 8 ns period
module tb_clkgen(
	output logic	clk
);

	initial clk = 1'b0;

	always #4 clk = ~clk;	//Half period

endmodule

`default_nettype wire

// File: testbench/qpll_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "qpll_ctrl_params.svh"

module qpll_checker(
	input wire			pclk,
	input wire			rst_n,
	input wire			psel,
	input wire			penable,
	input wire			pwrite,
	input wire[7:0]		paddr,
	input wire[31:0]	pwdata,
	input wire[31:0]	prdata,
	input wire			pready,
	input wire			pslverr,
	input wire[1:0]		qpll_reset,
	input wire[1:0]		qpll_powerdown,
	input wire[2:0]		refclk_sel0,
	input wire[2:0]		refclk_sel1,
	input wire[24:0]	sdm_data0,
	input wire[24:0]	sdm_data1,
	input wire[1:0]		sdm_toggle
);

	//Ages counted in samples from the LOAD access edge
	localparam int TOG_FIRST	= 3;		//Strobe, setup, then toggle
	localparam int TOG_LAST		= TOG_FIRST + `SDM_PULSE_CYCLES - 1;
	localparam int SEQ_LAST		= TOG_LAST + `SDM_HOLD_CYCLES;	//Busy ends here

	string			cur_test = "none";
	int				err_cnt = 0;
	int				test_err = 0;
	int				test_cnt = 0;
	int				fail_cnt = 0;
	int				pulse_cnt[2] = '{0, 0};	//Completed reset pulses
	int				width[2] = '{0, 0};
	logic[1:0]		pd_prev = 2'b00;

	//Shadow registers
	logic[31:0]		sh_ctrl;
	logic[24:0]		sh_sdm[2];

	//SDM sequence model
	bit				sq_active[2];
	int				sq_age[2];
	logic[24:0]		sq_word[2];
	logic[1:0]		start_now;
	logic			mapped;
	logic[24:0]		sdm_pin[2];

	assign sdm_pin[0] = sdm_data0;
	assign sdm_pin[1] = sdm_data1;

	//////////////////////////////////////////////////
	// Reporting

	task compare_value(input string what, input logic[31:0] exp, input logic[31:0] act);
		if(exp !== act) begin
			$display("CHECK FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
			err_cnt++;
			test_err++;
		end
	endtask

	task report_problem(input string msg);
		$display("ERROR %s: %s", cur_test, msg);
		err_cnt++;
		test_err++;
	endtask

	task begin_test(input string name);
		cur_test = name;
		test_err = 0;
	endtask

	task end_test;
		test_cnt++;
		if(test_err != 0) begin
			fail_cnt++;
			$display("test %s: %0d errors", cur_test, test_err);
		end
		else
			$display("test %s: ok", cur_test);
	endtask

	//////////////////////////////////////////////////
	// Per-cycle monitor

	always @(posedge pclk) begin
		if(!rst_n) begin
			sh_ctrl		= (32'(`REFCLK_SEL_DEFAULT) << 4) | 32'(`REFCLK_SEL_DEFAULT);
			sh_sdm		= '{25'h0, 25'h0};
			sq_active	= '{1'b0, 1'b0};
			sq_age		= '{0, 0};
			width		= '{0, 0};
			pd_prev		= 2'b00;
		end
		else begin
			//Static pins follow the shadow one cycle after the access
			compare_value("refclk_sel0 pin", 32'(sh_ctrl[2:0]), 32'(refclk_sel0));
			compare_value("refclk_sel1 pin", 32'(sh_ctrl[6:4]), 32'(refclk_sel1));
			compare_value("powerdown pins", 32'(sh_ctrl[9:8]), 32'(qpll_powerdown));

			for(int i = 0; i < 2; i++) begin
				compare_value("sdm_toggle", 32'(sq_active[i] && sq_age[i] >= TOG_FIRST &&
					sq_age[i] <= TOG_LAST), 32'(sdm_toggle[i]));
				if(sq_active[i] && sq_age[i] >= TOG_FIRST - 1)	//Setup through hold
					compare_value("sdm_data", 32'(sq_word[i]), 32'(sdm_pin[i]));

				//Reset pulse widths, power-down stretches are not pulses
				if(qpll_powerdown[i] && pd_prev[i])
					compare_value("qpll_reset in power-down", 32'd1, 32'(qpll_reset[i]));
				if(qpll_powerdown[i] || pd_prev[i])
					width[i] = 0;
				else if(qpll_reset[i])
					width[i]++;
				else if(width[i] != 0) begin
					compare_value("reset pulse width", `QPLL_RST_CYCLES, width[i]);
					pulse_cnt[i]++;
					width[i] = 0;
				end
			end
			pd_prev = qpll_powerdown;

			//////////////////////////////////////////////////
			// APB access phase

			start_now = 2'b00;
			if(psel && penable) begin
				compare_value("pready", 32'd1, 32'(pready));
				mapped = (paddr == `QPLL_ADDR_CTRL) || (paddr == `QPLL_ADDR_RESET) ||
					(paddr == `QPLL_ADDR_SDM_DATA0) || (paddr == `QPLL_ADDR_SDM_DATA1) ||
					(paddr == `QPLL_ADDR_SDM_LOAD) || (paddr == `QPLL_ADDR_STATUS);
				if(!mapped) begin
					compare_value("pslverr", 32'd1, 32'(pslverr));
					if(!pwrite)
						compare_value("unmapped read data", 32'd0, prdata);
				end
				else begin
					compare_value("pslverr", 32'd0, 32'(pslverr));
					if(pwrite) begin
						case(paddr)
							`QPLL_ADDR_CTRL:		sh_ctrl = pwdata & 32'h0000_0377;
							`QPLL_ADDR_SDM_DATA0:	sh_sdm[0] = pwdata[24:0];
							`QPLL_ADDR_SDM_DATA1:	sh_sdm[1] = pwdata[24:0];
							`QPLL_ADDR_SDM_LOAD: begin
								for(int i = 0; i < 2; i++)	//Busy loaders drop it
									if(pwdata[i] && (!sq_active[i] || sq_age[i] >= SEQ_LAST))
										start_now[i] = 1'b1;
							end
							default: begin
							end
						endcase
					end
					else begin
						case(paddr)
							`QPLL_ADDR_CTRL:		compare_value("CTRL read", sh_ctrl, prdata);
							`QPLL_ADDR_RESET:		compare_value("RESET read", 32'd0, prdata);
							`QPLL_ADDR_SDM_DATA0:	compare_value("SDM_DATA0 read",
								32'(sh_sdm[0]), prdata);
							`QPLL_ADDR_SDM_DATA1:	compare_value("SDM_DATA1 read",
								32'(sh_sdm[1]), prdata);
							`QPLL_ADDR_SDM_LOAD: begin
								compare_value("SDM_LOAD busy read",
									{30'h0, sq_active[1] && sq_age[1] >= TOG_FIRST - 1,
									sq_active[0] && sq_age[0] >= TOG_FIRST - 1}, prdata);
							end
							default: begin		//STATUS fields checked by the test
							end
						endcase
					end
				end
			end

			//Step the sequence model
			for(int i = 0; i < 2; i++) begin
				if(start_now[i]) begin
					sq_active[i]	= 1'b1;
					sq_age[i]		= 1;	//Next sample is one after the access
					sq_word[i]		= sh_sdm[i];
				end
				else if(sq_active[i]) begin
					sq_age[i]++;
					if(sq_age[i] > SEQ_LAST)
						sq_active[i] = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/qpll_ctrl_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module qpll_ctrl_asserts(
	input wire			pclk,
	input wire			rst_n,
	input wire			psel,
	input wire			penable,
	input wire			pwrite,
	input wire[7:0]		paddr,
	input wire[1:0]		sdm_toggle,
	input wire[24:0]	sdm_data0,
	input wire[24:0]	sdm_data1
);

	//////////////////////////////////////////////////
	// APB protocol

	a_enable_needs_sel: assert property (@(posedge pclk) disable iff (!rst_n)
		penable |-> psel) else $error("penable high without psel");

	a_setup_then_access: assert property (@(posedge pclk) disable iff (!rst_n)
		(psel && !penable) |=> (psel && penable && $stable(paddr) && $stable(pwrite)))
		else $error("setup phase not followed by a matching access phase");

	//////////////////////////////////////////////////
	// SDM toggle width and frozen data

	a_tog0_width: assert property (@(posedge pclk) disable iff (!rst_n)
		(!sdm_toggle[0] && $past(sdm_toggle[0])) |->
		($past(sdm_toggle[0], 2) && $past(sdm_toggle[0], 3) && !$past(sdm_toggle[0], 4)))
		else $error("sdm_toggle[0] pulse not three cycles");

	a_tog1_width: assert property (@(posedge pclk) disable iff (!rst_n)
		(!sdm_toggle[1] && $past(sdm_toggle[1])) |->
		($past(sdm_toggle[1], 2) && $past(sdm_toggle[1], 3) && !$past(sdm_toggle[1], 4)))
		else $error("sdm_toggle[1] pulse not three cycles");

	a_data0_stable: assert property (@(posedge pclk) disable iff (!rst_n)
		sdm_toggle[0] |-> $stable(sdm_data0)) else $error("sdm_data0 moved under toggle");

	a_data1_stable: assert property (@(posedge pclk) disable iff (!rst_n)
		sdm_toggle[1] |-> $stable(sdm_data1)) else $error("sdm_data1 moved under toggle");

endmodule

`default_nettype wire

// File: testbench/tb_qpll_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_qpll_ctrl;

	localparam logic[7:0] A_CTRL	= 8'h00;
	localparam logic[7:0] A_RESET	= 8'h04;
	localparam logic[7:0] A_DATA0	= 8'h08;
	localparam logic[7:0] A_LOAD	= 8'h10;
	localparam logic[7:0] A_STATUS	= 8'h14;

	wire			pclk;
	logic			rst_n;
	logic			psel;
	logic			penable;
	logic			pwrite;
	logic[7:0]		paddr;
	logic[31:0]		pwdata;
	wire[31:0]		prdata;
	wire			pready;
	wire			pslverr;
	logic[1:0]		qpll_lock = 2'b00;
	logic[1:0]		refclk_lost;
	logic[1:0]		fbclk_lost;
	wire[1:0]		qpll_reset;
	wire[1:0]		qpll_powerdown;
	wire[2:0]		qpll0_refclk_sel;
	wire[2:0]		qpll1_refclk_sel;
	wire[24:0]		sdm_data0;
	wire[24:0]		sdm_data1;
	wire[1:0]		sdm_toggle;

	//PLL model controls
	logic[1:0]		dead = 2'b00;		//Never locks
	logic[1:0]		drop = 2'b00;		//One-cycle lock loss
	int unsigned	lock_delay[2] = '{20, 20};
	int unsigned	wait_cnt[2] = '{0, 0};
	logic[31:0]		lfsr = 32'h62e4_d6fd;

	tb_clkgen u_clk(.clk(pclk));

	qpll_ctrl_top uut(.pclk(pclk), .rst_n(rst_n), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .qpll_lock(qpll_lock), .refclk_lost(refclk_lost),
		.fbclk_lost(fbclk_lost), .qpll_reset(qpll_reset), .qpll_powerdown(qpll_powerdown),
		.qpll0_refclk_sel(qpll0_refclk_sel), .qpll1_refclk_sel(qpll1_refclk_sel),
		.sdm_data0(sdm_data0), .sdm_data1(sdm_data1), .sdm_toggle(sdm_toggle));

	qpll_checker chk(.pclk(pclk), .rst_n(rst_n), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .qpll_reset(qpll_reset), .qpll_powerdown(qpll_powerdown),
		.refclk_sel0(qpll0_refclk_sel), .refclk_sel1(qpll1_refclk_sel),
		.sdm_data0(sdm_data0), .sdm_data1(sdm_data1), .sdm_toggle(sdm_toggle));

	bind qpll_ctrl_top qpll_ctrl_asserts u_asserts(.*);

	//////////////////////////////////////////////////
	// Random numbers, Galois LFSR

	function automatic logic[31:0] lfsr_next(input logic[31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task draw_bits(input int n, output logic[31:0] v);
		v = '0;
		for(int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);		//One step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task new_lock_delays;
		logic[31:0] r;
		for(int i = 0; i < 2; i++) begin
			draw_bits(7, r);
			lock_delay[i] = 20 + (r % 81);	//20 to 100 cycles
		end
	endtask

	//////////////////////////////////////////////////
	// PLL lock model, locks a while after reset falls

	always @(posedge pclk) begin
		for(int i = 0; i < 2; i++) begin
			if(qpll_reset[i] || qpll_powerdown[i] || dead[i] || drop[i]) begin
				qpll_lock[i]	<= 1'b0;
				wait_cnt[i]		<= lock_delay[i];
			end
			else if(wait_cnt[i] == 0)
				qpll_lock[i]	<= 1'b1;
			else
				wait_cnt[i]		<= wait_cnt[i] - 1;
		end
	end

	//////////////////////////////////////////////////
	// APB driver

	task apb_write(input logic[7:0] a, input logic[31:0] d);
		@(posedge pclk);
		psel	<= 1'b1;
		penable	<= 1'b0;
		pwrite	<= 1'b1;
		paddr	<= a;
		pwdata	<= d;
		@(posedge pclk);
		penable	<= 1'b1;
		@(posedge pclk);		//Access edge
		psel	<= 1'b0;
		penable	<= 1'b0;
	endtask

	task apb_read(input logic[7:0] a, output logic[31:0] d);
		@(posedge pclk);
		psel	<= 1'b1;
		penable	<= 1'b0;
		pwrite	<= 1'b0;
		paddr	<= a;
		@(posedge pclk);
		penable	<= 1'b1;
		@(negedge pclk);
		d = prdata;				//Mid access cycle
		@(posedge pclk);
		psel	<= 1'b0;
		penable	<= 1'b0;
	endtask

	//Poll one register bit, bounded
	task poll_bit(input logic[7:0] a, input int b, input logic want, input int tries,
		input string what);
		logic[31:0]	rd;
		int			n;
		n = 0;
		apb_read(a, rd);
		while(rd[b] !== want && n < tries) begin
			apb_read(a, rd);
			n++;
		end
		if(rd[b] !== want)
			chk.report_problem({"timed out waiting for ", what});
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	logic[31:0]	r;
	logic[31:0]	rd;
	int			p0;
	int			sel;

	initial begin
		rst_n		<= 1'b0;
		psel		<= 1'b0;
		penable		<= 1'b0;
		pwrite		<= 1'b0;
		paddr		<= 8'h00;
		pwdata		<= 32'h0;
		refclk_lost	<= 2'b00;
		fbclk_lost	<= 2'b00;
		new_lock_delays();
		repeat(10) @(posedge pclk);
		rst_n <= 1'b1;

		chk.begin_test("reset_and_lock");
		draw_bits(4, r);
		{fbclk_lost, refclk_lost} <= r[3:0];
		poll_bit(A_STATUS, 0, 1'b1, 200, "PLL0 lock");
		poll_bit(A_STATUS, 1, 1'b1, 200, "PLL1 lock");
		apb_read(A_STATUS, rd);
		chk.compare_value("lost flags", 32'(r[3:0]), 32'(rd[5:2]));
		chk.compare_value("PLL0 pulses", 32'd1, chk.pulse_cnt[0]);
		chk.compare_value("PLL1 pulses", 32'd1, chk.pulse_cnt[1]);
		draw_bits(1, r);
		sel = int'(r[0]);
		p0 = chk.pulse_cnt[sel];
		draw_bits(5, r);
		repeat(r[4:0]) @(posedge pclk);	//Random moment of the drop
		new_lock_delays();
		drop[sel] <= 1'b1;
		@(posedge pclk);
		drop[sel] <= 1'b0;
		poll_bit(A_STATUS, sel, 1'b0, 10, "lock loss");
		poll_bit(A_STATUS, sel, 1'b1, 200, "relock");
		chk.compare_value("pulses after drop", 32'(p0 + 1), chk.pulse_cnt[sel]);
		chk.end_test();

		chk.begin_test("register_rw");
		for(int k = 0; k < 8; k++) begin
			draw_bits(32, r);
			apb_write(A_CTRL, r & 32'hffff_fcff);	//Power-down stays off
			apb_read(A_CTRL, rd);
			draw_bits(32, r);
			apb_write(A_DATA0 + 8'(4 * (k % 2)), r);
			apb_read(A_DATA0 + 8'(4 * (k % 2)), rd);
		end
		chk.end_test();

		chk.begin_test("bad_address");
		for(int k = 0; k < 8; k++) begin
			draw_bits(8, r);
			if(r[1:0] == 2'b00 && r[7:0] <= 8'h14)
				r[0] = 1'b1;			//Force a miss
			draw_bits(32, rd);
			apb_write(r[7:0], rd);
			apb_read(r[7:0], rd);
			apb_read(A_CTRL, rd);
		end
		chk.end_test();

		chk.begin_test("sdm_load");
		for(int i = 0; i < 2; i++) begin
			draw_bits(25, r);
			apb_write(A_DATA0 + 8'(4 * i), r);
			apb_write(A_LOAD, 32'(1 << i));
			apb_read(A_LOAD, rd);
			chk.compare_value("busy during load", 32'd1, 32'(rd[i]));
			apb_write(A_LOAD, 32'(1 << i));	//Lands while busy
			poll_bit(A_LOAD, i, 1'b0, 20, "loader idle");
		end
		chk.end_test();

		chk.begin_test("dead_pll");
		p0 = chk.pulse_cnt[1];
		dead[1] <= 1'b1;
		poll_bit(A_STATUS, 7, 1'b1, 700, "PLL1 failed");
		chk.compare_value("pulses before fail", 32'(p0 + 3), chk.pulse_cnt[1]);
		repeat(40) @(posedge pclk);
		@(negedge pclk);
		chk.compare_value("qpll_reset in fail", 32'd0, 32'(qpll_reset[1]));
		chk.compare_value("pulses while failed", 32'(p0 + 3), chk.pulse_cnt[1]);
		dead[1] <= 1'b0;
		apb_write(A_RESET, 32'h2);
		apb_read(A_STATUS, rd);
		chk.compare_value("failed after reset request", 32'd0, 32'(rd[7]));
		poll_bit(A_STATUS, 1, 1'b1, 200, "PLL1 lock after restart");
		chk.compare_value("pulses after restart", 32'(p0 + 4), chk.pulse_cnt[1]);
		chk.end_test();

		chk.begin_test("powerdown");
		p0 = chk.pulse_cnt[0];
		draw_bits(8, r);
		apb_write(A_CTRL, {22'h0, 2'b01, r[7:0] & 8'h77});
		repeat(20) @(posedge pclk);
		apb_read(A_STATUS, rd);
		chk.compare_value("locked in power-down", 32'd0, 32'(rd[0]));
		@(negedge pclk);
		chk.compare_value("qpll_reset in power-down", 32'd1, 32'(qpll_reset[0]));
		new_lock_delays();
		apb_write(A_CTRL, {24'h0, r[7:0] & 8'h77});
		poll_bit(A_STATUS, 0, 1'b1, 200, "PLL0 lock after power-up");
		chk.compare_value("pulses after power-up", 32'(p0 + 1), chk.pulse_cnt[0]);
		chk.end_test();

		$display("tests %0d, failed %0d, errors %0d", chk.test_cnt, chk.fail_cnt,
			chk.err_cnt);
		if(chk.err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: qpll_ctrl_top.f
+incdir+hw
hw/qpll_regmap_pkg.sv
hw/qpll_ctrl_pkg.sv
hw/qpll_cfg_if.sv
hw/qpll_apb_regs.sv
hw/qpll_reset_ctl.sv
hw/qpll_sdm_loader.sv
hw/qpll_ctrl_top.sv
testbench/tb_clkgen.sv
testbench/qpll_checker.sv
testbench/qpll_ctrl_asserts.sv
testbench/tb_qpll_ctrl.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_qpll_ctrl -f qpll_ctrl_top.f -o tb_sim
	./obj_dir/tb_sim > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
